/* lsu_pipe.f */
verilog/lsu_pkg.sv
verilog/lsu_issue_select.sv
verilog/lsu_agen.sv
verilog/lsu_load_merge.sv
verilog/lsu_writeback.sv
verilog/lsu_pipe.sv
verif/lsu_pipe_tb.sv

/* Makefile */
SIM      ?= verilator
TOP      ?= lsu_pipe_tb
RTL_TOP  ?= lsu_pipe
FILELIST ?= lsu_pipe.f
FLAGS    ?= --binary --timing -j 0
OBJ_DIR  ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	$(SIM) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verif/lsu_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_tb
  import lsu_pkg::*;
;

  localparam int RV_ENTRY_SIZE   = 32;
  localparam int MEM_Q_SIZE      = 16;
  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 + RESET_CYCLES;
  localparam int SQ_DEPTH        = 2;
  localparam int SEED            = 32'h0a8b_9718;

  logic                     i_clk;
  logic                     i_reset_n;
  lsu_issue_t               rv_issue;
  logic [RV_ENTRY_SIZE-1:0] rv_index_oh;
  lsu_issue_t               replay_issue;
  logic [MEM_Q_SIZE-1:0]    replay_index_oh;
  logic                     rs_conflicted;
  logic [RV_ENTRY_SIZE-1:0] rs_conf_index_oh;
  l1d_req_t                 l1d_req;
  l1d_resp_t                l1d_resp;
  fwd_req_t                 fwd_req;
  fwd_resp_t                fwd_resp;
  ex1_update_t              ex1_update;
  ex2_update_t              ex2_update;
  phy_wr_t                  phy_wr;
  done_t                    done;

  // Memory and store-queue model
  logic [127:0] lines [16];
  logic         line_hit [16];
  logic         line_conflict [16];
  logic         sq_valid [SQ_DEPTH];
  logic [31:0]  sq_addr [SQ_DEPTH];
  logic [7:0]   sq_mask [SQ_DEPTH];  // Doubleword aligned
  logic [63:0]  sq_data [SQ_DEPTH];

  int checks;
  int mismatches;
  int failures;

  lsu_pipe #(
    .RV_ENTRY_SIZE (RV_ENTRY_SIZE),
    .MEM_Q_SIZE    (MEM_Q_SIZE)
  ) dut_i (
    .i_clk                  (i_clk),
    .i_reset_n              (i_reset_n),
    .i_rv_issue             (rv_issue),
    .i_rv_index_oh          (rv_index_oh),
    .i_replay_issue         (replay_issue),
    .i_replay_index_oh      (replay_index_oh),
    .o_ex0_rs_conflicted    (rs_conflicted),
    .o_ex0_rs_conf_index_oh (rs_conf_index_oh),
    .o_l1d_req              (l1d_req),
    .i_l1d_resp             (l1d_resp),
    .o_fwd_req              (fwd_req),
    .i_fwd_resp             (fwd_resp),
    .o_ex1_update           (ex1_update),
    .o_ex2_update           (ex2_update),
    .o_ex3_phy_wr           (phy_wr),
    .o_ex3_done             (done)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("TB FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Model helpers
  // --------------------------------------------------------------------------
  function automatic int sq_find(input logic [31:0] addr);
    int found;
    found = -1;
    for (int e = 0; e < SQ_DEPTH; e++) begin
      if (sq_valid[e] && sq_addr[e][31:3] == addr[31:3] && sq_mask[e][addr[2:0]]) begin
        found = e;  // Youngest entry wins
      end
    end
    return found;
  endfunction

  function automatic logic [7:0] mem_byte(input logic [31:0] addr);
    int e;
    e = sq_find(addr);
    if (e >= 0) return sq_data[e][int'(addr[2:0])*8 +: 8];
    return lines[addr[7:4]][int'(addr[3:0])*8 +: 8];
  endfunction

  function automatic logic [63:0] expect_load(input logic [31:0] addr, input logic [2:0] f3);
    logic [63:0] raw;
    int          nbytes;
    nbytes = 1 << f3[1:0];
    raw    = '0;
    for (int k = 0; k < nbytes; k++) raw[k*8 +: 8] = mem_byte(addr + 32'(k));
    if (!f3[2] && raw[nbytes*8-1]) begin
      for (int k = nbytes; k < 8; k++) raw[k*8 +: 8] = 8'hff;
    end
    return raw;
  endfunction

  function automatic haz_t expect_haz(input logic [31:0] addr, input logic [1:0] size);
    logic all_fwd;
    all_fwd = 1'b1;
    for (int k = 0; k < (1 << size); k++) begin
      if (sq_find(addr + 32'(k)) < 0) all_fwd = 1'b0;
    end
    if (all_fwd) return HAZ_NONE;
    if (line_conflict[addr[7:4]]) return HAZ_L1D_CONFLICT;
    if (!line_hit[addr[7:4]]) return HAZ_L1D_MISS;
    return HAZ_NONE;
  endfunction

  function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [11:0] imm);
    return {imm, 5'd1, f3, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic lsu_issue_t make_issue(input logic [31:0] inst, input logic [63:0] rs1,
                                            input logic [63:0] rs2, input logic [4:0] rd,
                                            input logic [5:0] cmt);
    return '{valid: 1'b1, inst: inst, rs1_data: rs1, rs2_data: rs2, rd: rd, cmt_id: cmt};
  endfunction

  // rs1 plus the I or S immediate
  function automatic logic [31:0] agen_addr(input lsu_issue_t item);
    logic [31:0] imm;
    if (item.inst[6:0] == 7'b0100011) imm = {{20{item.inst[31]}}, item.inst[31:25], item.inst[11:7]};
    else imm = {{20{item.inst[31]}}, item.inst[31:20]};
    return item.rs1_data[31:0] + imm;
  endfunction

  // Responses arrive one edge after the EX1 request
  always @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      l1d_resp <= '0;
      fwd_resp <= '0;
    end else begin
      l1d_resp <= '0;
      fwd_resp <= '0;
      if (l1d_req.valid) begin
        l1d_resp.hit      <= line_hit[l1d_req.paddr[7:4]];
        l1d_resp.conflict <= line_conflict[l1d_req.paddr[7:4]];
        l1d_resp.data     <= lines[l1d_req.paddr[7:4]];
      end
      if (fwd_req.valid) fwd_resp <= sq_lookup(fwd_req);
    end
  end

  function automatic fwd_resp_t sq_lookup(input fwd_req_t req);
    fwd_resp_t resp;
    int        e;
    int        pos;
    resp = '0;
    for (int k = 0; k < 8; k++) begin
      e   = sq_find(req.paddr + 32'(k));
      pos = int'(req.paddr[2:0]) + k;
      if (req.dw[k] && e >= 0 && pos < 8) begin
        resp.dw[k]            = 1'b1;
        resp.data[pos*8 +: 8] = sq_data[e][pos*8 +: 8];
      end
    end
    return resp;
  endfunction

  task automatic sq_set(input int e, input logic [31:0] addr, input logic [7:0] mask);
    sq_valid[e] = 1'b1;
    sq_addr[e]  = addr;
    sq_mask[e]  = mask;
    sq_data[e]  = {$urandom, $urandom};
  endtask

  task automatic sq_clear();
    for (int e = 0; e < SQ_DEPTH; e++) sq_valid[e] = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic check_phy_wr(input string name, input phy_wr_t exp, input phy_wr_t act);
    checks++;
    if (exp.valid !== act.valid || (exp.valid && (exp.rd !== act.rd || exp.data !== act.data)))
    begin
      mismatches++;
      $display("mismatch %s phy_wr: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_done(input string name, input done_t exp, input done_t act);
    checks++;
    if (exp.valid !== act.valid || (exp.valid && exp.cmt_id !== act.cmt_id)) begin
      mismatches++;
      $display("mismatch %s done: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_ex1_update(input string name, input ex1_update_t exp,
                                  input ex1_update_t act);
    checks++;
    if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
      mismatches++;
      $display("mismatch %s ex1_update: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_ex2_update(input string name, input ex2_update_t exp,
                                  input ex2_update_t act);
    checks++;
    if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
      mismatches++;
      $display("mismatch %s ex2_update: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_l1d_req(input string name, input l1d_req_t exp, input l1d_req_t act);
    checks++;
    if (exp.valid !== act.valid || (exp.valid && exp.paddr !== act.paddr)) begin
      mismatches++;
      $display("mismatch %s l1d_req: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_fwd_req(input string name, input fwd_req_t exp, input fwd_req_t act);
    checks++;
    if (exp.valid !== act.valid || (exp.valid && exp !== act)) begin
      mismatches++;
      $display("mismatch %s fwd_req: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_conflict(input string name, input logic exp_flag,
                                input logic [RV_ENTRY_SIZE-1:0] exp_idx,
                                input logic act_flag, input logic [RV_ENTRY_SIZE-1:0] act_idx);
    checks++;
    if (exp_flag !== act_flag || (exp_flag && exp_idx !== act_idx)) begin
      mismatches++;
      $display("mismatch %s conflict: expected %b/%h actual %b/%h",
               name, exp_flag, exp_idx, act_flag, act_idx);
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic drive_station(input lsu_issue_t item);
    @(posedge i_clk);
    rv_issue    <= item;
    rv_index_oh <= item.valid ? (32'h1 << item.cmt_id[4:0]) : '0;
  endtask

  // One station item through EX1, EX2 and EX3
  task automatic run_single(input string name, input lsu_issue_t item);
    logic        is_store;
    logic [31:0] addr;
    haz_t        haz;
    logic        fin;
    logic [7:0]  need;
    is_store = item.inst[6:0] == 7'b0100011;
    addr     = agen_addr(item);
    haz      = is_store ? HAZ_NONE : expect_haz(addr, item.inst[13:12]);
    fin      = is_store || haz == HAZ_NONE;
    need     = 8'((1 << (1 << item.inst[13:12])) - 1);  // Low bytes of the access
    drive_station(item);
    drive_station('0);
    @(posedge i_clk);
    @(negedge i_clk);
    check_ex1_update(name, '{valid: 1'b1, cmt_id: item.cmt_id, index_oh: '0, paddr: addr,
                             st_data: item.rs2_data, size: size_t'(item.inst[13:12])},
                     ex1_update);
    check_l1d_req(name, '{valid: !is_store, paddr: {addr[31:4], 4'h0}}, l1d_req);
    check_fwd_req(name, '{valid: !is_store, paddr: addr, dw: need}, fwd_req);
    @(negedge i_clk);
    check_ex2_update(name, '{valid: 1'b1, cmt_id: item.cmt_id, index_oh: '0, haz: haz},
                     ex2_update);
    @(negedge i_clk);
    check_done(name, '{valid: fin, cmt_id: item.cmt_id}, done);
    check_phy_wr(name, '{valid: fin && !is_store && item.rd != 5'd0, rd: item.rd,
                         data: is_store ? '0 : expect_load(addr, item.inst[14:12])}, phy_wr);
  endtask

  task automatic test_load_sizes();
    logic [31:0] addr;
    int          ofs;
    for (int f = 0; f < 7; f++) begin
      ofs  = (((f * 5 + 3) % 16) >> (f % 4)) << (f % 4);  // Aligned offset
      addr = 32'(((f + 1) << 4) | ofs);
      run_single($sformatf("load funct3=%0d", f),
                 make_issue(enc_load(3'(f), 5'd3, 12'hff0), 64'(addr) + 64'h10, '0, 5'd3, 6'(f)));
    end
  endtask

  task automatic test_store_update();
    run_single("store sd", make_issue(enc_store(3'd3, 12'h7f8), {$urandom, $urandom},
                                      {$urandom, $urandom}, 5'd0, 6'd10));
    run_single("store sw", make_issue(enc_store(3'd2, 12'h014), {$urandom, $urandom},
                                      {$urandom, $urandom}, 5'd0, 6'd11));
  endtask

  task automatic test_forwarding();
    sq_set(0, 32'h058, 8'hff);
    line_hit[5] = 1'b0;
    run_single("full forward", make_issue(enc_load(3'd3, 5'd7, 12'h058), '0, '0, 5'd7, 6'd12));
    line_hit[5] = 1'b1;
    sq_clear();
    sq_set(1, 32'h060, 8'h0f);
    run_single("partial forward", make_issue(enc_load(3'd3, 5'd8, 12'h060), '0, '0, 5'd8, 6'd13));
    sq_clear();
  endtask

  task automatic test_hazards();
    sq_set(0, 32'h070, 8'h03);
    line_hit[7] = 1'b0;
    run_single("miss", make_issue(enc_load(3'd3, 5'd9, 12'h070), '0, '0, 5'd9, 6'd14));
    line_hit[7] = 1'b1;
    sq_clear();
    line_conflict[8] = 1'b1;
    run_single("conflict", make_issue(enc_load(3'd2, 5'd9, 12'h084), '0, '0, 5'd9, 6'd15));
    line_conflict[8] = 1'b0;
    run_single("rd zero", make_issue(enc_load(3'd3, 5'd0, 12'h090), '0, '0, 5'd0, 6'd16));
  endtask

  task automatic test_replay_collision();
    lsu_issue_t rp_item;
    rp_item = make_issue(enc_load(3'd2, 5'd6, 12'h0b4), '0, '0, 5'd6, 6'd21);
    drive_station(make_issue(enc_load(3'd3, 5'd5, 12'h0a0), '0, '0, 5'd5, 6'd20));
    @(posedge i_clk);  // Station entry now in EX0
    rv_issue        <= '0;
    rv_index_oh     <= '0;
    replay_issue    <= rp_item;
    replay_index_oh <= 16'h0010;
    @(negedge i_clk);
    check_conflict("replay collision", 1'b1, 32'h1 << 20, rs_conflicted, rs_conf_index_oh);
    @(posedge i_clk);
    replay_issue    <= '0;
    replay_index_oh <= '0;
    @(negedge i_clk);
    check_conflict("replay collision", 1'b0, '0, rs_conflicted, rs_conf_index_oh);
    check_ex1_update("replay collision", '{valid: 1'b1, cmt_id: 6'd21, index_oh: 16'h0010,
                                           paddr: 32'h0b4, st_data: '0, size: SIZE_W},
                     ex1_update);
    @(negedge i_clk);
    check_ex2_update("replay collision",
                     '{valid: 1'b1, cmt_id: 6'd21, index_oh: 16'h0010, haz: HAZ_NONE}, ex2_update);
    @(negedge i_clk);
    check_done("replay collision", '{valid: 1'b1, cmt_id: 6'd21}, done);
    check_phy_wr("replay collision",
                 '{valid: 1'b1, rd: 5'd6, data: expect_load(32'h0b4, 3'd2)}, phy_wr);
    @(negedge i_clk);
    check_done("dropped station entry", '{valid: 1'b0, cmt_id: '0}, done);
  endtask

  task automatic test_back_to_back();
    lsu_issue_t items [4];
    phy_wr_t    exp [4];
    for (int i = 0; i < 4; i++) begin
      items[i] = make_issue(enc_load(3'd3, 5'(10 + i), 12'(8 * i)), 64'h0c0, '0,
                            5'(10 + i), 6'(30 + i));
      exp[i]   = '{valid: 1'b1, rd: 5'(10 + i), data: expect_load(32'(32'h0c0 + 8 * i), 3'd3)};
    end
    for (int i = 0; i < 4; i++) drive_station(items[i]);
    drive_station('0);
    for (int i = 0; i < 4; i++) begin
      @(negedge i_clk);
      check_phy_wr($sformatf("back to back %0d", i), exp[i], phy_wr);
      check_done($sformatf("back to back %0d", i), '{valid: 1'b1, cmt_id: 6'(30 + i)}, done);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    checks          = 0;
    mismatches      = 0;
    failures        = 0;
    i_reset_n       = 1'b0;
    rv_issue        = '0;
    rv_index_oh     = '0;
    replay_issue    = '0;
    replay_index_oh = '0;
    l1d_resp        = '0;
    fwd_resp        = '0;
    for (int l = 0; l < 16; l++) begin
      lines[l]         = {$urandom, $urandom, $urandom, $urandom};
      line_hit[l]      = 1'b1;
      line_conflict[l] = 1'b0;
    end
    sq_clear();

    repeat (RESET_CYCLES) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    if (rs_conflicted || l1d_req.valid || fwd_req.valid || ex1_update.valid ||
        ex2_update.valid || phy_wr.valid || done.valid) begin
      failures++;
      $display("a valid output was still high after reset");
    end

    test_load_sizes();
    test_store_update();
    test_forwarding();
    test_hazards();
    test_replay_collision();
    test_back_to_back();

    repeat (2) @(posedge i_clk);
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/lsu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe
  import lsu_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 32,
  parameter int MEM_Q_SIZE    = 16
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  lsu_issue_t               i_rv_issue,
  input  logic [RV_ENTRY_SIZE-1:0] i_rv_index_oh,
  input  lsu_issue_t               i_replay_issue,
  input  logic [MEM_Q_SIZE-1:0]    i_replay_index_oh,

  output logic                     o_ex0_rs_conflicted,
  output logic [RV_ENTRY_SIZE-1:0] o_ex0_rs_conf_index_oh,

  output l1d_req_t                 o_l1d_req,
  input  l1d_resp_t                i_l1d_resp,
  output fwd_req_t                 o_fwd_req,
  input  fwd_resp_t                i_fwd_resp,

  output ex1_update_t              o_ex1_update,
  output ex2_update_t              o_ex2_update,

  output phy_wr_t                  o_ex3_phy_wr,
  output done_t                    o_ex3_done
);

  // --------------------------------------------------------------------------
  // Stage to stage wires
  // --------------------------------------------------------------------------
  lsu_issue_t            w_ex0_issue;
  logic [MEM_Q_SIZE-1:0] w_ex0_index_oh;

  lsu_issue_t            w_ex1_issue;
  lsu_ctrl_t             w_ex1_ctrl;
  logic [ADDR_W-1:0]     w_ex1_paddr;
  logic [MEM_Q_SIZE-1:0] w_ex1_index_oh;

  lsu_issue_t            w_ex2_issue;
  logic                  w_ex2_complete;
  logic [XLEN_W-1:0]     w_ex2_data;

  lsu_issue_select #(
    .RV_ENTRY_SIZE (RV_ENTRY_SIZE),
    .MEM_Q_SIZE    (MEM_Q_SIZE)
  ) u_issue_select (
    .i_clk                  (i_clk),
    .i_reset_n              (i_reset_n),
    .i_rv_issue             (i_rv_issue),
    .i_rv_index_oh          (i_rv_index_oh),
    .i_replay_issue         (i_replay_issue),
    .i_replay_index_oh      (i_replay_index_oh),
    .o_ex0_rs_conflicted    (o_ex0_rs_conflicted),
    .o_ex0_rs_conf_index_oh (o_ex0_rs_conf_index_oh),
    .o_ex0_issue            (w_ex0_issue),
    .o_ex0_index_oh         (w_ex0_index_oh)
  );

  lsu_agen #(
    .MEM_Q_SIZE (MEM_Q_SIZE)
  ) u_agen (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex0_issue    (w_ex0_issue),
    .i_ex0_index_oh (w_ex0_index_oh),
    .o_l1d_req      (o_l1d_req),
    .o_fwd_req      (o_fwd_req),
    .o_ex1_update   (o_ex1_update),
    .o_ex1_issue    (w_ex1_issue),
    .o_ex1_ctrl     (w_ex1_ctrl),
    .o_ex1_paddr    (w_ex1_paddr),
    .o_ex1_index_oh (w_ex1_index_oh)
  );

  lsu_load_merge #(
    .MEM_Q_SIZE (MEM_Q_SIZE)
  ) u_load_merge (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex1_issue    (w_ex1_issue),
    .i_ex1_ctrl     (w_ex1_ctrl),
    .i_ex1_paddr    (w_ex1_paddr),
    .i_ex1_index_oh (w_ex1_index_oh),
    .i_l1d_resp     (i_l1d_resp),
    .i_fwd_resp     (i_fwd_resp),
    .o_ex2_update   (o_ex2_update),
    .o_ex2_issue    (w_ex2_issue),
    .o_ex2_complete (w_ex2_complete),
    .o_ex2_data     (w_ex2_data)
  );

  lsu_writeback u_writeback (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex2_issue    (w_ex2_issue),
    .i_ex2_complete (w_ex2_complete),
    .i_ex2_data     (w_ex2_data),
    .o_ex3_phy_wr   (o_ex3_phy_wr),
    .o_ex3_done     (o_ex3_done)
  );

endmodule

`default_nettype wire

/* verilog/lsu_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_writeback
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  lsu_issue_t        i_ex2_issue,
  input  logic              i_ex2_complete,
  input  logic [XLEN_W-1:0] i_ex2_data,

  output phy_wr_t           o_ex3_phy_wr,
  output done_t             o_ex3_done
);

  lsu_issue_t        r_ex3_issue;
  logic              r_ex3_complete;
  logic [XLEN_W-1:0] r_ex3_data;
  lsu_ctrl_t         w_ex3_ctrl;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_issue    <= '0;
      r_ex3_complete <= 1'b0;
    end else begin
      r_ex3_issue    <= i_ex2_issue;
      r_ex3_complete <= i_ex2_complete;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3_data <= i_ex2_data;
  end

  assign w_ex3_ctrl = decode_ctrl(r_ex3_issue.inst);

  assign o_ex3_done.valid  = r_ex3_issue.valid & r_ex3_complete;
  assign o_ex3_done.cmt_id = r_ex3_issue.cmt_id;

  // x0 is never written
  assign o_ex3_phy_wr.valid = o_ex3_done.valid & (w_ex3_ctrl.op == OP_LOAD) &
                              (r_ex3_issue.rd != 5'd0);
  assign o_ex3_phy_wr.rd    = r_ex3_issue.rd;
  assign o_ex3_phy_wr.data  = r_ex3_data;

endmodule

`default_nettype wire

/* verilog/lsu_load_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_merge
  import lsu_pkg::*;
#(
  parameter int MEM_Q_SIZE = 16
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  lsu_issue_t            i_ex1_issue,
  input  lsu_ctrl_t             i_ex1_ctrl,
  input  logic [ADDR_W-1:0]     i_ex1_paddr,
  input  logic [MEM_Q_SIZE-1:0] i_ex1_index_oh,

  input  l1d_resp_t             i_l1d_resp,
  input  fwd_resp_t             i_fwd_resp,

  output ex2_update_t           o_ex2_update,
  output lsu_issue_t            o_ex2_issue,
  output logic                  o_ex2_complete,
  output logic [XLEN_W-1:0]     o_ex2_data
);

  lsu_issue_t            r_ex2_issue;
  lsu_ctrl_t             r_ex2_ctrl;
  logic [MEM_Q_SIZE-1:0] r_ex2_index_oh;
  logic [ADDR_W-1:0]     r_ex2_paddr;

  logic [XLEN_W-1:0]     w_l1d_dw;
  logic [XLEN_W-1:0]     w_fwd_data;
  logic [XLEN_W-1:0]     w_merged;
  logic [XLEN_W-1:0]     w_ext;
  logic [XLEN_B-1:0]     w_need;
  logic                  w_all_fwd;
  logic                  w_ex2_load;
  haz_t                  w_haz;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_issue    <= '0;
      r_ex2_ctrl     <= '{size: SIZE_B, sign: SIGN_U, op: OP_NONE};
      r_ex2_index_oh <= '0;
    end else begin
      r_ex2_issue    <= i_ex1_issue;
      r_ex2_ctrl     <= i_ex1_ctrl;
      r_ex2_index_oh <= i_ex1_index_oh;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_paddr <= i_ex1_paddr;
  end

  // --------------------------------------------------------------------------
  // Byte merge
  // --------------------------------------------------------------------------
  assign w_l1d_dw = i_l1d_resp.data[r_ex2_paddr[DCACHE_OFS_W-1:DW_OFS_W] * XLEN_W +: XLEN_W]
                    >> {r_ex2_paddr[DW_OFS_W-1:0], 3'b000};
  assign w_fwd_data = i_fwd_resp.data >> {r_ex2_paddr[DW_OFS_W-1:0], 3'b000};

  always_comb begin
    for (int b = 0; b < XLEN_B; b++) begin
      w_merged[b*8 +: 8] = i_fwd_resp.dw[b] ? w_fwd_data[b*8 +: 8] : w_l1d_dw[b*8 +: 8];
    end
  end

  assign w_need     = size_mask(r_ex2_ctrl.size);
  assign w_all_fwd  = &(~w_need | i_fwd_resp.dw);
  assign w_ex2_load = r_ex2_ctrl.op == OP_LOAD;

  // Forwarding covers everything, so the cache state does not matter
  always_comb begin
    if (!w_ex2_load || w_all_fwd) begin
      w_haz = HAZ_NONE;
    end else if (i_l1d_resp.conflict) begin
      w_haz = HAZ_L1D_CONFLICT;
    end else if (!i_l1d_resp.hit) begin
      w_haz = HAZ_L1D_MISS;
    end else begin
      w_haz = HAZ_NONE;
    end
  end

  // --------------------------------------------------------------------------
  // Extension
  // --------------------------------------------------------------------------
  always_comb begin
    case (r_ex2_ctrl.size)
      SIZE_B:  w_ext = {{(XLEN_W-8){r_ex2_ctrl.sign == SIGN_S && w_merged[7]}}, w_merged[7:0]};
      SIZE_H:  w_ext = {{(XLEN_W-16){r_ex2_ctrl.sign == SIGN_S && w_merged[15]}},
                        w_merged[15:0]};
      SIZE_W:  w_ext = {{(XLEN_W-32){r_ex2_ctrl.sign == SIGN_S && w_merged[31]}},
                        w_merged[31:0]};
      default: w_ext = w_merged;
    endcase
  end

  always_comb begin
    o_ex2_update.valid    = r_ex2_issue.valid;
    o_ex2_update.cmt_id   = r_ex2_issue.cmt_id;
    o_ex2_update.index_oh = MEM_Q_IDX_W'(r_ex2_index_oh);
    o_ex2_update.haz      = w_haz;
  end

  assign o_ex2_issue    = r_ex2_issue;
  assign o_ex2_complete = r_ex2_issue.valid &
                          ((r_ex2_ctrl.op == OP_STORE) | (w_ex2_load & (w_haz == HAZ_NONE)));
  assign o_ex2_data     = w_ext;

endmodule

`default_nettype wire

/* verilog/lsu_agen.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_agen
  import lsu_pkg::*;
#(
  parameter int MEM_Q_SIZE = 16
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,

  input  lsu_issue_t            i_ex0_issue,
  input  logic [MEM_Q_SIZE-1:0] i_ex0_index_oh,

  output l1d_req_t              o_l1d_req,
  output fwd_req_t              o_fwd_req,
  output ex1_update_t           o_ex1_update,

  output lsu_issue_t            o_ex1_issue,
  output lsu_ctrl_t             o_ex1_ctrl,
  output logic [ADDR_W-1:0]     o_ex1_paddr,
  output logic [MEM_Q_SIZE-1:0] o_ex1_index_oh
);

  lsu_issue_t            r_ex1_issue;
  logic [MEM_Q_SIZE-1:0] r_ex1_index_oh;

  lsu_ctrl_t             w_ex1_ctrl;
  logic [ADDR_W-1:0]     w_imm_i;
  logic [ADDR_W-1:0]     w_imm_s;
  logic [ADDR_W-1:0]     w_ex1_paddr;
  logic                  w_ex1_load;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue    <= '0;
      r_ex1_index_oh <= '0;
    end else begin
      r_ex1_issue    <= i_ex0_issue;
      r_ex1_index_oh <= i_ex0_index_oh;
    end
  end

  // --------------------------------------------------------------------------
  // Decode and address generation
  // --------------------------------------------------------------------------
  assign w_ex1_ctrl = decode_ctrl(r_ex1_issue.inst);
  assign w_ex1_load = r_ex1_issue.valid & (w_ex1_ctrl.op == OP_LOAD);

  assign w_imm_i = {{(ADDR_W-12){r_ex1_issue.inst[31]}}, r_ex1_issue.inst[31:20]};
  assign w_imm_s = {{(ADDR_W-12){r_ex1_issue.inst[31]}},
                    r_ex1_issue.inst[31:25], r_ex1_issue.inst[11:7]};

  // Bare mode, so the sum is already physical
  assign w_ex1_paddr = r_ex1_issue.rs1_data[ADDR_W-1:0] +
                       ((w_ex1_ctrl.op == OP_STORE) ? w_imm_s : w_imm_i);

  // --------------------------------------------------------------------------
  // L1D read and store-queue probe
  // --------------------------------------------------------------------------
  always_comb begin
    o_l1d_req.valid = w_ex1_load;
    o_l1d_req.paddr = {w_ex1_paddr[ADDR_W-1:DCACHE_OFS_W], {DCACHE_OFS_W{1'b0}}};

    o_fwd_req.valid = w_ex1_load;
    o_fwd_req.paddr = w_ex1_paddr;
    o_fwd_req.dw    = size_mask(w_ex1_ctrl.size);
  end

  // Address and store data for the LDQ/STQ
  always_comb begin
    o_ex1_update.valid    = r_ex1_issue.valid;
    o_ex1_update.cmt_id   = r_ex1_issue.cmt_id;
    o_ex1_update.index_oh = MEM_Q_IDX_W'(r_ex1_index_oh);
    o_ex1_update.paddr    = w_ex1_paddr;
    o_ex1_update.st_data  = r_ex1_issue.rs2_data;
    o_ex1_update.size     = w_ex1_ctrl.size;
  end

  assign o_ex1_issue    = r_ex1_issue;
  assign o_ex1_ctrl     = w_ex1_ctrl;
  assign o_ex1_paddr    = w_ex1_paddr;
  assign o_ex1_index_oh = r_ex1_index_oh;

endmodule

`default_nettype wire

/* verilog/lsu_issue_select.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_select
  import lsu_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 32,
  parameter int MEM_Q_SIZE    = 16
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  lsu_issue_t               i_rv_issue,
  input  logic [RV_ENTRY_SIZE-1:0] i_rv_index_oh,

  input  lsu_issue_t               i_replay_issue,
  input  logic [MEM_Q_SIZE-1:0]    i_replay_index_oh,

  output logic                     o_ex0_rs_conflicted,
  output logic [RV_ENTRY_SIZE-1:0] o_ex0_rs_conf_index_oh,
  output lsu_issue_t               o_ex0_issue,
  output logic [MEM_Q_SIZE-1:0]    o_ex0_index_oh
);

  lsu_issue_t               r_ex0_rs_issue;
  logic [RV_ENTRY_SIZE-1:0] r_ex0_rs_index_oh;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_rs_issue    <= '0;
      r_ex0_rs_index_oh <= '0;
    end else begin
      r_ex0_rs_issue    <= i_rv_issue;
      r_ex0_rs_index_oh <= i_rv_index_oh;
    end
  end

  // Replay from the memory queue always has priority
  always_comb begin
    if (i_replay_issue.valid) begin
      o_ex0_issue    = i_replay_issue;
      o_ex0_index_oh = i_replay_index_oh;
    end else begin
      o_ex0_issue    = r_ex0_rs_issue;
      o_ex0_index_oh = '0;  // Station entries carry no queue index
    end
  end

  // Station must reissue the dropped entry
  assign o_ex0_rs_conflicted    = i_replay_issue.valid & r_ex0_rs_issue.valid;
  assign o_ex0_rs_conf_index_oh = r_ex0_rs_index_oh;

endmodule

`default_nettype wire

/* verilog/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  localparam int XLEN_W          = 64;
  localparam int XLEN_B          = XLEN_W / 8;
  localparam int DW_OFS_W        = $clog2(XLEN_B);
  localparam int ADDR_W          = 32;
  localparam int DCACHE_DATA_B_W = 16;
  localparam int DCACHE_OFS_W    = $clog2(DCACHE_DATA_B_W);
  localparam int CMT_ID_W        = 6;
  localparam int MEM_Q_IDX_W     = 16;  // Queue index field in the updates

  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef enum logic [1:0] {SIZE_B, SIZE_H, SIZE_W, SIZE_DW} size_t;
  typedef enum logic {SIGN_U, SIGN_S} sign_t;
  typedef enum logic [1:0] {OP_LOAD, OP_STORE, OP_NONE} op_t;
  typedef enum logic [1:0] {HAZ_NONE, HAZ_L1D_CONFLICT, HAZ_L1D_MISS} haz_t;

  // --------------------------------------------------------------------------
  // Pipe payloads
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic                valid;
    logic [31:0]         inst;
    logic [XLEN_W-1:0]   rs1_data;
    logic [XLEN_W-1:0]   rs2_data;
    logic [4:0]          rd;
    logic [CMT_ID_W-1:0] cmt_id;
  } lsu_issue_t;

  typedef struct packed {
    size_t size;
    sign_t sign;
    op_t   op;
  } lsu_ctrl_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] paddr;  // Line aligned
  } l1d_req_t;

  typedef struct packed {
    logic                           hit;
    logic                           conflict;
    logic [DCACHE_DATA_B_W*8-1:0]   data;
  } l1d_resp_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] paddr;
    logic [XLEN_B-1:0] dw;
  } fwd_req_t;

  typedef struct packed {
    logic [XLEN_B-1:0] dw;
    logic [XLEN_W-1:0] data;  // Doubleword aligned
  } fwd_resp_t;

  typedef struct packed {
    logic                   valid;
    logic [CMT_ID_W-1:0]    cmt_id;
    logic [MEM_Q_IDX_W-1:0] index_oh;
    logic [ADDR_W-1:0]      paddr;
    logic [XLEN_W-1:0]      st_data;
    size_t                  size;
  } ex1_update_t;

  typedef struct packed {
    logic                   valid;
    logic [CMT_ID_W-1:0]    cmt_id;
    logic [MEM_Q_IDX_W-1:0] index_oh;
    haz_t                   haz;
  } ex2_update_t;

  typedef struct packed {
    logic              valid;
    logic [4:0]        rd;
    logic [XLEN_W-1:0] data;
  } phy_wr_t;

  typedef struct packed {
    logic                valid;
    logic [CMT_ID_W-1:0] cmt_id;
  } done_t;

  function automatic lsu_ctrl_t decode_ctrl(input logic [31:0] inst);
    lsu_ctrl_t ctrl;
    ctrl.size = size_t'(inst[13:12]);
    ctrl.sign = inst[14] ? SIGN_U : SIGN_S;  // LBU/LHU/LWU set funct3[2]
    case (inst[6:0])
      OPC_LOAD:  ctrl.op = OP_LOAD;
      OPC_STORE: ctrl.op = OP_STORE;
      default:   ctrl.op = OP_NONE;
    endcase
    return ctrl;
  endfunction

  // Low bytes touched by an access of this size
  function automatic logic [XLEN_B-1:0] size_mask(input size_t size);
    logic [XLEN_B-1:0] mask;
    case (size)
      SIZE_B:  mask = 8'h01;
      SIZE_H:  mask = 8'h03;
      SIZE_W:  mask = 8'h0f;
      default: mask = 8'hff;
    endcase
    return mask;
  endfunction

endpackage

`default_nettype wire
